/* common/multipu_params.svh */
/*
 * size macros for the multi-PU pi1 subsystem
 *  PI1_PUCOUNT   number of PU master ports
 *  PI1_ARCHBITSZ width of a pi1 data word in bits
 *  PI1_ADDRBITSZ width of a pi1 word address
 */

`ifndef MULTIPU_PARAMS_SVH
`define MULTIPU_PARAMS_SVH

// each PU owns one master port
`define PI1_PUCOUNT 4

`define PI1_ARCHBITSZ 32

// byte offset within a word is not carried on the bus
`define PI1_ADDRBITSZ (`PI1_ARCHBITSZ - $clog2(`PI1_ARCHBITSZ / 8))

`endif

/* common/multipu_pkg.sv */
/*
 * shared pi1 types
 *  pi1_op_t, the bus operation
 *  pi1_data_t, pi1_addr_t and pi1_sel_t for the word, address and byte selects
 *  pu_idx_t for a PU index
 */

`include "multipu_params.svh"

package multipu_pkg;

	// encodings follow the pi1 convention
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10,
		PI1_RW  = 2'b11
	} pi1_op_t;

	// keep one bit of index even for a single PU
	localparam int PU_IDX_W = (`PI1_PUCOUNT > 1) ? $clog2(`PI1_PUCOUNT) : 1;

	typedef logic [`PI1_ARCHBITSZ-1:0]     pi1_data_t;
	typedef logic [`PI1_ADDRBITSZ-1:0]     pi1_addr_t;
	typedef logic [(`PI1_ARCHBITSZ/8)-1:0] pi1_sel_t;
	typedef logic [PU_IDX_W-1:0]           pu_idx_t;

endpackage

/* perint/pi1_master_port.sv */
/*
 * pi1_master_port
 *  captures one request from a PU while the port is free
 *  holds it pending until the slave port completes it
 *  returns the read word and a ready level to the PU
 */

`timescale 1ns/1ps

module pi1_master_port #(
	parameter int unsigned PU_IDX = 0
) (
	input  logic                  clk_i,
	input  logic                  arst_n_i,

	input  multipu_pkg::pi1_op_t   pi1_op_i,
	input  multipu_pkg::pi1_addr_t pi1_addr_i,
	input  multipu_pkg::pi1_data_t pi1_data_i,
	input  multipu_pkg::pi1_sel_t  pi1_sel_i,
	output multipu_pkg::pi1_data_t pi1_data_o,
	output logic                   pi1_rdy_o,

	input  logic                   done_i,
	input  multipu_pkg::pu_idx_t   done_idx_i,
	input  multipu_pkg::pi1_data_t rdata_i,

	output logic                   pend_o,
	output multipu_pkg::pi1_op_t   req_op_o,
	output multipu_pkg::pi1_addr_t req_addr_o,
	output multipu_pkg::pi1_data_t req_data_o,
	output multipu_pkg::pi1_sel_t  req_sel_o
);

	logic                   busy_q;
	logic                   capture_w;
	logic                   hit_w;
	multipu_pkg::pi1_op_t   op_q;
	multipu_pkg::pi1_addr_t addr_q;
	multipu_pkg::pi1_data_t wdata_q;
	multipu_pkg::pi1_sel_t  sel_q;
	multipu_pkg::pi1_data_t rdata_q;

	// a request is taken only while the port is free
	assign capture_w = !busy_q && (pi1_op_i != multipu_pkg::PI1_NOP);
	// completion meant for this port
	assign hit_w = busy_q && done_i && (done_idx_i == multipu_pkg::pu_idx_t'(PU_IDX));

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q <= 1'b0;
		end else if (capture_w) begin
			busy_q <= 1'b1;
		end else if (hit_w) begin
			busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (capture_w) begin
			op_q    <= pi1_op_i;
			addr_q  <= pi1_addr_i;
			wdata_q <= pi1_data_i;
			sel_q   <= pi1_sel_i;
		end
		// read word lines up with pi1_rdy_o going high
		if (hit_w) begin
			rdata_q <= rdata_i;
		end
	end

	assign pi1_rdy_o  = !busy_q;
	assign pi1_data_o = rdata_q;

	assign pend_o     = busy_q;
	assign req_op_o   = op_q;
	assign req_addr_o = addr_q;
	assign req_data_o = wdata_q;
	assign req_sel_o  = sel_q;

endmodule

/* perint/pi1_arbiter.sv */
/*
 * pi1_arbiter
 *  round-robin choice among pending master ports
 *  the grant is registered while the bus is free and held until done
 *  the search starts one past the last PU served
 */

`timescale 1ns/1ps

`include "multipu_params.svh"

module pi1_arbiter (
	input  logic                       clk_i,
	input  logic                       arst_n_i,

	input  logic [`PI1_PUCOUNT-1:0]    pend_i,
	input  logic                       done_i,

	output logic                       gnt_valid_o,
	output multipu_pkg::pu_idx_t       gnt_idx_o
);

	localparam int PUCOUNT = `PI1_PUCOUNT;

	multipu_pkg::pu_idx_t ptr_q;
	multipu_pkg::pu_idx_t gnt_idx_q;
	logic                 gnt_valid_q;

	multipu_pkg::pu_idx_t cand;
	multipu_pkg::pu_idx_t pick;
	multipu_pkg::pu_idx_t pick_next;
	logic                 found;

	// walk once around the ring starting at the pointer
	always_comb begin
		cand  = ptr_q;
		pick  = ptr_q;
		found = 1'b0;
		for (int i = 0; i < PUCOUNT; i++) begin
			if (!found && pend_i[cand]) begin
				found = 1'b1;
				pick  = cand;
			end
			if (cand == multipu_pkg::pu_idx_t'(PUCOUNT - 1))
				cand = '0;
			else
				cand = cand + 1'b1;
		end
	end

	// PU count need not be a power of two
	assign pick_next = (pick == multipu_pkg::pu_idx_t'(PUCOUNT - 1)) ? '0 : pick + 1'b1;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			gnt_valid_q <= 1'b0;
			gnt_idx_q   <= '0;
			ptr_q       <= '0;
		end else if (!gnt_valid_q) begin
			if (found) begin
				gnt_valid_q <= 1'b1;
				gnt_idx_q   <= pick;
				ptr_q       <= pick_next;
			end
		end else if (done_i) begin
			// bus is free again from the next cycle
			gnt_valid_q <= 1'b0;
		end
	end

	assign gnt_valid_o = gnt_valid_q;
	assign gnt_idx_o   = gnt_idx_q;

endmodule

/* perint/pi1_slave_port.sv */
/*
 * pi1_slave_port
 *  loads the granted master's request onto the shared pi1 bus
 *  holds the bus steady while the memory is not ready
 *  signals completion with the PU index and the read word
 */

`timescale 1ns/1ps

`include "multipu_params.svh"

module pi1_slave_port (
	input  logic                   clk_i,
	input  logic                   arst_n_i,

	input  logic                   gnt_valid_i,
	input  multipu_pkg::pu_idx_t   gnt_idx_i,

	input  multipu_pkg::pi1_op_t   req_op_i   [`PI1_PUCOUNT],
	input  multipu_pkg::pi1_addr_t req_addr_i [`PI1_PUCOUNT],
	input  multipu_pkg::pi1_data_t req_data_i [`PI1_PUCOUNT],
	input  multipu_pkg::pi1_sel_t  req_sel_i  [`PI1_PUCOUNT],

	output multipu_pkg::pi1_op_t   pi1_op_o,
	output multipu_pkg::pi1_addr_t pi1_addr_o,
	output multipu_pkg::pi1_data_t pi1_data_o,
	input  multipu_pkg::pi1_data_t pi1_data_i,
	output multipu_pkg::pi1_sel_t  pi1_sel_o,
	input  logic                   pi1_rdy_i,

	output logic                   done_o,
	output multipu_pkg::pu_idx_t   done_idx_o,
	output multipu_pkg::pi1_data_t rdata_o
);

	multipu_pkg::pi1_op_t   op_q;
	multipu_pkg::pi1_addr_t addr_q;
	multipu_pkg::pi1_data_t data_q;
	multipu_pkg::pi1_sel_t  sel_q;
	multipu_pkg::pu_idx_t   idx_q;
	logic                   load_w;
	logic                   done_w;

	// a new grant goes out only onto an idle bus
	assign load_w = gnt_valid_i && (op_q == multipu_pkg::PI1_NOP);
	// transfer ends on the first ready cycle with a live op
	assign done_w = (op_q != multipu_pkg::PI1_NOP) && pi1_rdy_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			op_q <= multipu_pkg::PI1_NOP;
		end else if (done_w) begin
			op_q <= multipu_pkg::PI1_NOP;
		end else if (load_w) begin
			op_q <= req_op_i[gnt_idx_i];
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_w) begin
			addr_q <= req_addr_i[gnt_idx_i];
			data_q <= req_data_i[gnt_idx_i];
			sel_q  <= req_sel_i[gnt_idx_i];
			idx_q  <= gnt_idx_i;
		end
	end

	assign pi1_op_o   = op_q;
	assign pi1_addr_o = addr_q;
	assign pi1_data_o = data_q;
	assign pi1_sel_o  = sel_q;

	// read word passes straight through, the master port registers it
	assign done_o     = done_w;
	assign done_idx_o = idx_q;
	assign rdata_o    = pi1_data_i;

endmodule

/* design/multipu_pi1.sv */
/*
 * multipu_pi1
 *  multi-master side of the pi1 interconnect
 *  one pi1_master_port per PU, a round-robin pi1_arbiter
 *  and a pi1_slave_port driving the shared bus
 */

`timescale 1ns/1ps

`include "multipu_params.svh"

module multipu_pi1 (
	input  logic                   clk_i,
	input  logic                   arst_n_i,

	// PU side, one entry per master port
	input  multipu_pkg::pi1_op_t   m_pi1_op_i   [`PI1_PUCOUNT],
	input  multipu_pkg::pi1_addr_t m_pi1_addr_i [`PI1_PUCOUNT],
	input  multipu_pkg::pi1_data_t m_pi1_data_i [`PI1_PUCOUNT],
	input  multipu_pkg::pi1_sel_t  m_pi1_sel_i  [`PI1_PUCOUNT],
	output multipu_pkg::pi1_data_t m_pi1_data_o [`PI1_PUCOUNT],
	output logic                   m_pi1_rdy_o  [`PI1_PUCOUNT],

	// shared memory side
	output multipu_pkg::pi1_op_t   pi1_op_o,
	output multipu_pkg::pi1_addr_t pi1_addr_o,
	output multipu_pkg::pi1_data_t pi1_data_o,
	input  multipu_pkg::pi1_data_t pi1_data_i,
	output multipu_pkg::pi1_sel_t  pi1_sel_o,
	input  logic                   pi1_rdy_i
);

	logic [`PI1_PUCOUNT-1:0] pend_w;
	multipu_pkg::pi1_op_t    req_op_w   [`PI1_PUCOUNT];
	multipu_pkg::pi1_addr_t  req_addr_w [`PI1_PUCOUNT];
	multipu_pkg::pi1_data_t  req_data_w [`PI1_PUCOUNT];
	multipu_pkg::pi1_sel_t   req_sel_w  [`PI1_PUCOUNT];

	logic                    gnt_valid_w;
	multipu_pkg::pu_idx_t    gnt_idx_w;

	logic                    done_w;
	multipu_pkg::pu_idx_t    done_idx_w;
	multipu_pkg::pi1_data_t  rdata_w;

	genvar gen_pu_idx;
	generate for (gen_pu_idx = 0; gen_pu_idx < `PI1_PUCOUNT; gen_pu_idx++) begin : gen_pu
		pi1_master_port #(
			.PU_IDX (gen_pu_idx)
		) u_mport (
			.clk_i      (clk_i),
			.arst_n_i   (arst_n_i),
			.pi1_op_i   (m_pi1_op_i[gen_pu_idx]),
			.pi1_addr_i (m_pi1_addr_i[gen_pu_idx]),
			.pi1_data_i (m_pi1_data_i[gen_pu_idx]),
			.pi1_sel_i  (m_pi1_sel_i[gen_pu_idx]),
			.pi1_data_o (m_pi1_data_o[gen_pu_idx]),
			.pi1_rdy_o  (m_pi1_rdy_o[gen_pu_idx]),
			.done_i     (done_w),
			.done_idx_i (done_idx_w),
			.rdata_i    (rdata_w),
			.pend_o     (pend_w[gen_pu_idx]),
			.req_op_o   (req_op_w[gen_pu_idx]),
			.req_addr_o (req_addr_w[gen_pu_idx]),
			.req_data_o (req_data_w[gen_pu_idx]),
			.req_sel_o  (req_sel_w[gen_pu_idx])
		);
	end endgenerate

	pi1_arbiter u_arb (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.pend_i      (pend_w),
		.done_i      (done_w),
		.gnt_valid_o (gnt_valid_w),
		.gnt_idx_o   (gnt_idx_w)
	);

	pi1_slave_port u_sport (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.gnt_valid_i (gnt_valid_w),
		.gnt_idx_i   (gnt_idx_w),
		.req_op_i    (req_op_w),
		.req_addr_i  (req_addr_w),
		.req_data_i  (req_data_w),
		.req_sel_i   (req_sel_w),
		.pi1_op_o    (pi1_op_o),
		.pi1_addr_o  (pi1_addr_o),
		.pi1_data_o  (pi1_data_o),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_o   (pi1_sel_o),
		.pi1_rdy_i   (pi1_rdy_i),
		.done_o      (done_w),
		.done_idx_o  (done_idx_w),
		.rdata_o     (rdata_w)
	);

endmodule

/* testbench/multipu_pi1_checker.sv */
/*
 * multipu_pi1_checker
 *  assertions on the shared pi1 slave bus and the arbiter grant
 */

`timescale 1ns/1ps

module multipu_pi1_checker (
	input  logic                   clk_i,
	input  logic                   arst_n_i,
	input  multipu_pkg::pi1_op_t   op_i,
	input  multipu_pkg::pi1_addr_t addr_i,
	input  multipu_pkg::pi1_data_t data_i,
	input  multipu_pkg::pi1_sel_t  sel_i,
	input  logic                   rdy_i,
	input  logic                   done_i,
	input  multipu_pkg::pu_idx_t   done_idx_i,
	input  logic                   gnt_valid_i,
	input  multipu_pkg::pu_idx_t   gnt_idx_i
);

	// request stays put until the memory takes it
	bus_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(op_i != multipu_pkg::PI1_NOP && !rdy_i) |=>
			($stable(op_i) && $stable(addr_i) && $stable(data_i) && $stable(sel_i)))
		else $error("slave bus changed while pi1_rdy_i was low");

	// a completion belongs to the master that still holds the grant
	done_owner_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		done_i |-> (gnt_valid_i && done_idx_i == gnt_idx_i))
		else $error("done pulsed for a PU that does not hold the grant");

	// grant is held until its transfer is done
	gnt_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(gnt_valid_i && !done_i) |=> (gnt_valid_i && $stable(gnt_idx_i)))
		else $error("grant changed before done");

endmodule

/* testbench/tb_multipu_pi1.sv */
/*
 * tb_multipu_pi1
 *  four random PU masters and a memory model with random stalls
 *  compare tasks for slave-bus requests and returned read words
 *  round-robin wait count per PU, watchdog
 */

`timescale 1ns/1ps

`include "multipu_params.svh"

module tb_multipu_pi1;

	localparam int PUS       = `PI1_PUCOUNT;
	localparam int REQS      = 200;
	localparam int WIN       = 16;
	localparam int MAX_STALL = 12;
	// grant, load, stall, done and return to the PU
	localparam int WORST_CYC = MAX_STALL + 4;
	localparam int LIMIT_NS  = REQS * PUS * WORST_CYC * 2 * 100;
	localparam int unsigned ADDR_BASE = 'h40;

	logic                   clk = 1'b0;
	logic                   arst_n;
	multipu_pkg::pi1_op_t   m_op    [PUS];
	multipu_pkg::pi1_addr_t m_addr  [PUS];
	multipu_pkg::pi1_data_t m_wdata [PUS];
	multipu_pkg::pi1_sel_t  m_sel   [PUS];
	multipu_pkg::pi1_data_t m_rdata [PUS];
	logic                   m_rdy   [PUS];
	multipu_pkg::pi1_op_t   s_op;
	multipu_pkg::pi1_addr_t s_addr;
	multipu_pkg::pi1_data_t s_wdata;
	multipu_pkg::pi1_data_t s_rdata;
	multipu_pkg::pi1_sel_t  s_sel;
	logic                   s_rdy;

	// per-PU model: the captured request and where it stands
	multipu_pkg::pi1_op_t   req_op   [PUS];
	multipu_pkg::pi1_addr_t req_addr [PUS];
	multipu_pkg::pi1_data_t req_data [PUS];
	multipu_pkg::pi1_sel_t  req_sel  [PUS];
	multipu_pkg::pi1_data_t exp_rdata [PUS];
	logic outst [PUS];
	logic on_bus [PUS];
	logic returning [PUS];
	int   issued [PUS];
	int   completed [PUS];
	int   waits [PUS];

	multipu_pkg::pi1_data_t mem [WIN];
	logic bus_busy;
	int   bus_pu;
	int   stall;

	always #50 clk = ~clk;

	multipu_pi1 u_dut (
		.clk_i        (clk),
		.arst_n_i     (arst_n),
		.m_pi1_op_i   (m_op),
		.m_pi1_addr_i (m_addr),
		.m_pi1_data_i (m_wdata),
		.m_pi1_sel_i  (m_sel),
		.m_pi1_data_o (m_rdata),
		.m_pi1_rdy_o  (m_rdy),
		.pi1_op_o     (s_op),
		.pi1_addr_o   (s_addr),
		.pi1_data_o   (s_wdata),
		.pi1_data_i   (s_rdata),
		.pi1_sel_o    (s_sel),
		.pi1_rdy_i    (s_rdy)
	);

	bind pi1_slave_port multipu_pi1_checker u_chk (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.op_i        (pi1_op_o),
		.addr_i      (pi1_addr_o),
		.data_i      (pi1_data_o),
		.sel_i       (pi1_sel_o),
		.rdy_i       (pi1_rdy_i),
		.done_i      (done_o),
		.done_idx_i  (done_idx_o),
		.gnt_valid_i (gnt_valid_i),
		.gnt_idx_i   (gnt_idx_i)
	);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_req(input string name,
			input multipu_pkg::pi1_op_t exp_op, input multipu_pkg::pi1_addr_t exp_addr,
			input multipu_pkg::pi1_data_t exp_data, input multipu_pkg::pi1_sel_t exp_sel,
			input multipu_pkg::pi1_op_t act_op, input multipu_pkg::pi1_addr_t act_addr,
			input multipu_pkg::pi1_data_t act_data, input multipu_pkg::pi1_sel_t act_sel);
		if (exp_op !== act_op || exp_addr !== act_addr || exp_data !== act_data
				|| exp_sel !== act_sel)
			stop_with_error($sformatf(
				"MISMATCH %s expected %s a=%h d=%h s=%h actual %s a=%h d=%h s=%h", name,
				exp_op.name(), exp_addr, exp_data, exp_sel,
				act_op.name(), act_addr, act_data, act_sel));
	endtask

	task automatic check_rdata(input string name, input multipu_pkg::pi1_data_t exp_w,
			input multipu_pkg::pi1_data_t act_w);
		if (exp_w !== act_w)
			stop_with_error($sformatf("MISMATCH %s expected %h actual %h", name, exp_w, act_w));
	endtask

	function automatic multipu_pkg::pi1_data_t fill_word(input int unsigned addr);
		return multipu_pkg::pi1_data_t'(addr * 32'h9e3779b1) ^ 32'h5a5a_0000;
	endfunction

	function automatic multipu_pkg::pi1_data_t merge_bytes(input multipu_pkg::pi1_data_t old_w,
			input multipu_pkg::pi1_data_t new_w, input multipu_pkg::pi1_sel_t sel);
		multipu_pkg::pi1_data_t res;
		res = old_w;
		for (int b = 0; b < `PI1_ARCHBITSZ / 8; b++) begin
			if (sel[b])
				res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic logic all_done();
		for (int p = 0; p < PUS; p++) begin
			if (completed[p] != REQS)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// ready level and read word seen by each PU
	task automatic check_returns();
		for (int p = 0; p < PUS; p++) begin
			if (returning[p]) begin
				if (!m_rdy[p])
					stop_with_error($sformatf("PU %0d not ready after its completion", p));
				if (req_op[p] != multipu_pkg::PI1_WR)
					check_rdata($sformatf("read_return_pu%0d", p), exp_rdata[p], m_rdata[p]);
				completed[p]++;
				outst[p]     = 1'b0;
				on_bus[p]    = 1'b0;
				returning[p] = 1'b0;
			end else if (outst[p] && m_rdy[p]) begin
				stop_with_error($sformatf("PU %0d ready without a slave completion", p));
			end else if (!outst[p] && !m_rdy[p]) begin
				stop_with_error($sformatf("PU %0d busy with no request", p));
			end
		end
	endtask

	// a new slave transfer is matched by its write word
	task automatic watch_bus();
		int owner;
		owner = -1;
		if (!bus_busy && s_op != multipu_pkg::PI1_NOP) begin
			for (int p = 0; p < PUS; p++) begin
				if (owner < 0 && outst[p] && !on_bus[p] && req_data[p] == s_wdata)
					owner = p;
			end
			if (owner < 0)
				stop_with_error("slave request matches no outstanding PU request");
			check_req("slave_request", req_op[owner], req_addr[owner], req_data[owner],
				req_sel[owner], s_op, s_addr, s_wdata, s_sel);
			on_bus[owner] = 1'b1;
			bus_pu   = owner;
			bus_busy = 1'b1;
			stall    = ($urandom % 32 == 0) ? MAX_STALL : int'($urandom % 4);
		end
	endtask

	task automatic drive_pus();
		for (int p = 0; p < PUS; p++) begin
			if (!outst[p] && issued[p] < REQS && $urandom % 4 != 0) begin
				req_op[p]   = multipu_pkg::pi1_op_t'(2'(1 + $urandom % 3));
				req_addr[p] = multipu_pkg::pi1_addr_t'(ADDR_BASE + $urandom % WIN);
				req_data[p] = multipu_pkg::pi1_data_t'($urandom);
				req_sel[p]  = multipu_pkg::pi1_sel_t'($urandom);
				m_op[p]     = req_op[p];
				m_addr[p]   = req_addr[p];
				m_wdata[p]  = req_data[p];
				m_sel[p]    = req_sel[p];
				outst[p]    = 1'b1;
				waits[p]    = 0;
				issued[p]++;
			end else begin
				m_op[p] = multipu_pkg::PI1_NOP;
			end
		end
	endtask

	// memory answers after the chosen stall and applies the byte selects
	task automatic drive_mem();
		multipu_pkg::pi1_data_t old_w;
		int idx;
		s_rdata = multipu_pkg::pi1_data_t'($urandom);
		s_rdy   = 1'b0;
		if (bus_busy && stall > 0) begin
			stall--;
		end else if (bus_busy) begin
			idx   = int'(s_addr[3:0]);
			old_w = mem[idx];
			s_rdy   = 1'b1;
			s_rdata = old_w;
			if (s_op != multipu_pkg::PI1_RD)
				mem[idx] = merge_bytes(old_w, s_wdata, s_sel);
			exp_rdata[bus_pu] = old_w;
			returning[bus_pu] = 1'b1;
			bus_busy = 1'b0;
			for (int q = 0; q < PUS; q++) begin
				if (q != bus_pu && outst[q] && !returning[q]) begin
					waits[q]++;
					if (waits[q] > PUS - 1)
						stop_with_error($sformatf("PU %0d passed over by %0d transfers",
							q, waits[q]));
				end
			end
		end
	endtask

	initial begin
		#(LIMIT_NS);
		stop_with_error("watchdog expired before all requests completed");
	end

	initial begin
		void'($urandom(88369));
		arst_n   = 1'b0;
		s_rdy    = 1'b0;
		s_rdata  = '0;
		bus_busy = 1'b0;
		bus_pu   = 0;
		stall    = 0;
		for (int p = 0; p < PUS; p++) begin
			m_op[p]      = multipu_pkg::PI1_NOP;
			m_addr[p]    = '0;
			m_wdata[p]   = '0;
			m_sel[p]     = '0;
			outst[p]     = 1'b0;
			on_bus[p]    = 1'b0;
			returning[p] = 1'b0;
			issued[p]    = 0;
			completed[p] = 0;
			waits[p]     = 0;
		end
		for (int i = 0; i < WIN; i++)
			mem[i] = fill_word(ADDR_BASE + i);
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		while (!all_done()) begin
			@(negedge clk);
			check_returns();
			watch_bus();
			drive_pus();
			drive_mem();
		end
		if (s_op != multipu_pkg::PI1_NOP) begin
			stop_with_error("slave bus op not idle after the last completion");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

/* sources.f */
+incdir+common
common/multipu_pkg.sv
perint/pi1_master_port.sv
perint/pi1_arbiter.sv
perint/pi1_slave_port.sv
design/multipu_pi1.sv
testbench/multipu_pi1_checker.sv
testbench/tb_multipu_pi1.sv

/* run.sh */
#!/bin/sh
# build and run the multipu_pi1 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_multipu_pi1 -f sources.f -o sim_multipu_pi1

# the log decides the result, so a stopped simulation must not end the script here
./obj_dir/sim_multipu_pi1 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Regression passed$" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi
